/* rtl/dma_defs.svh */
// --------------------------------------------------
// DMA write engine widths
// address, word size, burst length and word count
// shared by the package and the RTL blocks
// --------------------------------------------------

`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// byte address
`define DMA_ADDR_WIDTH  32

// log2 of bytes per word, 2 gives 32-bit words
`define DMA_DATA_SIZE   2
`define DMA_DATA_WIDTH  (8 << `DMA_DATA_SIZE)
`define DMA_STRB_WIDTH  (1 << `DMA_DATA_SIZE)

// AXI4 awlen
`define DMA_LEN_WIDTH   8

// transfer size in words
`define DMA_COUNT_WIDTH (`DMA_ADDR_WIDTH - `DMA_DATA_SIZE)

`endif

/* rtl/dma_pkg.sv */
// --------------------------------------------------
// DMA write engine types
// channel payloads passed between the blocks
// --------------------------------------------------

`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

	// one AW burst, length in beats minus one
	typedef struct packed {
		logic [`DMA_ADDR_WIDTH-1:0] addr;
		logic [`DMA_LEN_WIDTH-1:0]  len;
	} aw_cmd_t;

	// one W beat
	typedef struct packed {
		logic [`DMA_DATA_WIDTH-1:0] data;
		logic                       last;
	} w_beat_t;

	// burst length handed to the W side
	typedef struct packed {
		logic [`DMA_LEN_WIDTH-1:0] len;
	} len_cmd_t;

endpackage

`default_nettype wire

/* rtl/skid_buffer.sv */
// --------------------------------------------------
// Skid buffer
// two-entry register slice for a valid/ready channel,
// registered ready and valid, one item per cycle
// --------------------------------------------------

`default_nettype none

module skid_buffer #(
	parameter int WIDTH = 8
) (
	input  wire              aclk,
	input  wire              aresetn,

	input  wire  [WIDTH-1:0] s_data,
	input  wire              s_valid,
	output logic             s_ready,

	output logic [WIDTH-1:0] m_data,
	output logic             m_valid,
	input  wire              m_ready
);

	logic [WIDTH-1:0] spare_data;
	logic             spare_valid;
	logic             spare_valid_next;
	logic             s_fire;
	logic             main_free;

	assign s_fire    = s_valid && s_ready;
	// main register empties or moves on this cycle
	assign main_free = !m_valid || m_ready;

	// spare fills only when the main register is stalled
	always_comb begin
		spare_valid_next = spare_valid;
		if (main_free) begin
			spare_valid_next = 1'b0;
		end else if (s_fire) begin
			spare_valid_next = 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			m_valid     <= 1'b0;
			spare_valid <= 1'b0;
			s_ready     <= 1'b0;
		end else begin
			spare_valid <= spare_valid_next;
			s_ready     <= !spare_valid_next;
			if (main_free) begin
				m_valid <= spare_valid || s_fire;
			end
		end
	end

	// s_ready is low while spare is full, so no input then
	always_ff @(posedge aclk) begin
		if (main_free) begin
			if (spare_valid) begin
				m_data <= spare_data;
			end else if (s_fire) begin
				m_data <= s_data;
			end
		end else if (s_fire) begin
			spare_data <= s_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/burst_addr_gen.sv */
// --------------------------------------------------
// Burst address generator
// splits a transfer into INCR bursts, issues AW and
// length commands, counts outstanding B responses
// --------------------------------------------------

`default_nettype none

`include "dma_defs.svh"

module burst_addr_gen (
	input  wire                          aclk,
	input  wire                          aresetn,

	input  wire                          enable,
	input  wire  [`DMA_ADDR_WIDTH-1:0]   param_addr,
	input  wire  [`DMA_COUNT_WIDTH-1:0]  param_count,
	input  wire  [`DMA_LEN_WIDTH-1:0]    param_maxlen,

	output dma_pkg::aw_cmd_t             aw_cmd,
	output logic                         aw_valid,
	input  wire                          aw_ready,

	output dma_pkg::len_cmd_t            len_cmd,
	output logic                         len_valid,
	input  wire                          len_ready,

	input  wire                          bvalid,
	input  wire  [1:0]                   bresp,

	output logic                         busy,
	output logic                         resp_error
);

	import dma_pkg::*;

	localparam int ADDR_W  = `DMA_ADDR_WIDTH;
	localparam int LEN_W   = `DMA_LEN_WIDTH;
	localparam int COUNT_W = `DMA_COUNT_WIDTH;

	aw_cmd_t            cur_r;
	logic [LEN_W-1:0]   maxlen_r;
	logic [COUNT_W-1:0] remain_r;
	logic [COUNT_W-1:0] outstanding_r;
	logic               run_r;

	logic [COUNT_W-1:0] first_beats;
	logic [COUNT_W-1:0] next_beats;
	logic [ADDR_W-1:0]  burst_bytes;
	logic               start;
	logic               aw_fire;
	logic               both_taken;
	logic               next_burst;

	// beats of one burst, capped at maxlen+1
	function automatic logic [COUNT_W-1:0] burst_beats(
		input logic [COUNT_W-1:0] count,
		input logic [LEN_W-1:0]   maxlen
	);
		logic [COUNT_W-1:0] limit;
		limit = COUNT_W'(maxlen) + COUNT_W'(1);
		return (count < limit) ? count : limit;
	endfunction

	assign busy        = run_r || (outstanding_r != '0);
	assign start       = enable && !busy;
	assign aw_fire     = aw_valid && aw_ready;
	assign first_beats = burst_beats(param_count, param_maxlen);
	assign next_beats  = burst_beats(remain_r, maxlen_r);
	assign burst_bytes = (ADDR_W'(cur_r.len) + ADDR_W'(1)) << `DMA_DATA_SIZE;

	// address and length both gone, or leaving this cycle
	assign both_taken  = run_r && (!aw_valid || aw_ready) && (!len_valid || len_ready);
	assign next_burst  = both_taken && (remain_r != '0);

	assign aw_cmd      = cur_r;
	assign len_cmd.len = cur_r.len;

	// --------------------------------------------------
	// issue control
	// --------------------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			run_r         <= 1'b0;
			aw_valid      <= 1'b0;
			len_valid     <= 1'b0;
			remain_r      <= '0;
			outstanding_r <= '0;
			resp_error    <= 1'b0;
		end else begin
			if (start) begin
				run_r     <= 1'b1;
				aw_valid  <= 1'b1;
				len_valid <= 1'b1;
				remain_r  <= param_count - first_beats;
			end else if (run_r) begin
				if (aw_ready) begin
					aw_valid <= 1'b0;
				end
				if (len_ready) begin
					len_valid <= 1'b0;
				end
				if (next_burst) begin
					aw_valid  <= 1'b1;
					len_valid <= 1'b1;
					remain_r  <= remain_r - next_beats;
				end else if (both_taken) begin
					run_r <= 1'b0;
				end
			end

			// bursts on the bus awaiting B
			case ({aw_fire, bvalid})
				2'b10:   outstanding_r <= outstanding_r + 1'b1;
				2'b01:   outstanding_r <= outstanding_r - 1'b1;
				default: outstanding_r <= outstanding_r;
			endcase

			// sticky until the next transfer
			if (start) begin
				resp_error <= 1'b0;
			end else if (bvalid && (bresp != 2'b00)) begin
				resp_error <= 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// burst address and length
	// --------------------------------------------------
	always_ff @(posedge aclk) begin
		if (start) begin
			maxlen_r   <= param_maxlen;
			cur_r.addr <= param_addr;
			cur_r.len  <= LEN_W'(first_beats - COUNT_W'(1));
		end else if (next_burst) begin
			cur_r.addr <= cur_r.addr + burst_bytes;
			cur_r.len  <= LEN_W'(next_beats - COUNT_W'(1));
		end
	end

endmodule

`default_nettype wire

/* rtl/wdata_sequencer.sv */
// --------------------------------------------------
// W data sequencer
// joins the stream to the W channel one burst at a
// time, counting beats and flagging the last one
// --------------------------------------------------

`default_nettype none

`include "dma_defs.svh"

module wdata_sequencer (
	input  wire                          aclk,
	input  wire                          aresetn,

	input  wire  [`DMA_STRB_WIDTH-1:0]   param_wstrb,

	input  wire  dma_pkg::len_cmd_t      cmd,
	input  wire                          cmd_valid,
	output logic                         cmd_ready,

	input  wire  [`DMA_DATA_WIDTH-1:0]   s_data,
	input  wire                          s_valid,
	output logic                         s_ready,

	output dma_pkg::w_beat_t             w_beat,
	output logic                         w_valid,
	input  wire                          w_ready,

	output logic [`DMA_STRB_WIDTH-1:0]   wstrb,
	output logic                         wbusy
);

	localparam int LEN_W = `DMA_LEN_WIDTH;

	logic [LEN_W-1:0] cnt_r;
	logic [LEN_W-1:0] cnt_cur;
	logic             active;
	logic             cmd_fire;
	logic             w_fire;

	// a waiting command opens its burst in the same cycle
	assign active    = wbusy || cmd_valid;
	assign cmd_ready = !wbusy;
	assign cmd_fire  = cmd_valid && cmd_ready;

	// beats left after this one
	assign cnt_cur   = wbusy ? cnt_r : cmd.len;

	// stream passes straight through while a burst is open
	assign w_valid     = active && s_valid;
	assign s_ready     = active && w_ready;
	assign w_fire      = w_valid && w_ready;
	assign w_beat.data = s_data;
	assign w_beat.last = (cnt_cur == '0);

	// --------------------------------------------------
	// burst state
	// --------------------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wbusy <= 1'b0;
		end else if (w_fire && w_beat.last) begin
			wbusy <= 1'b0;
		end else if (cmd_fire) begin
			wbusy <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (w_fire) begin
			cnt_r <= cnt_cur - 1'b1;
		end else if (cmd_fire) begin
			cnt_r <= cmd.len;
		end
	end

	// byte strobes of the transfer, loaded with each burst command
	always_ff @(posedge aclk) begin
		if (cmd_fire) begin
			wstrb <= param_wstrb;
		end
	end

endmodule

`default_nettype wire

/* rtl/axi4_dma_writer.sv */
// --------------------------------------------------
// AXI4 DMA writer
// AXI4-Stream words to memory over AXI4 write bursts,
// register slices on AW, W, stream and the command path
// --------------------------------------------------

`default_nettype none

`include "dma_defs.svh"

module axi4_dma_writer (
	input  wire                          aclk,
	input  wire                          aresetn,

	// control
	input  wire                          enable,
	output logic                         busy,
	output logic                         resp_error,

	input  wire  [`DMA_ADDR_WIDTH-1:0]   param_addr,
	input  wire  [`DMA_COUNT_WIDTH-1:0]  param_count,
	input  wire  [`DMA_LEN_WIDTH-1:0]    param_maxlen,
	input  wire  [`DMA_STRB_WIDTH-1:0]   param_wstrb,

	// stream input
	input  wire  [`DMA_DATA_WIDTH-1:0]   s_axis_tdata,
	input  wire                          s_axis_tvalid,
	output logic                         s_axis_tready,

	// AXI4 write master
	output logic [`DMA_ADDR_WIDTH-1:0]   m_axi_awaddr,
	output logic [`DMA_LEN_WIDTH-1:0]    m_axi_awlen,
	output logic                         m_axi_awvalid,
	input  wire                          m_axi_awready,
	output logic [`DMA_DATA_WIDTH-1:0]   m_axi_wdata,
	output logic [`DMA_STRB_WIDTH-1:0]   m_axi_wstrb,
	output logic                         m_axi_wlast,
	output logic                         m_axi_wvalid,
	input  wire                          m_axi_wready,
	input  wire  [1:0]                   m_axi_bresp,
	input  wire                          m_axi_bvalid
);

	import dma_pkg::*;

	aw_cmd_t                    gen_aw;
	aw_cmd_t                    out_aw;
	logic                       gen_aw_valid;
	logic                       gen_aw_ready;

	len_cmd_t                   gen_len;
	len_cmd_t                   seq_cmd;
	logic                       gen_len_valid;
	logic                       gen_len_ready;
	logic                       seq_cmd_valid;
	logic                       seq_cmd_ready;

	logic [`DMA_DATA_WIDTH-1:0] seq_s_data;
	logic                       seq_s_valid;
	logic                       seq_s_ready;

	w_beat_t                    seq_w;
	w_beat_t                    out_w;
	logic                       seq_w_valid;
	logic                       seq_w_ready;

	logic                       gen_busy;
	logic                       wbusy;

	// --------------------------------------------------
	// control side
	// --------------------------------------------------
	burst_addr_gen burst_addr_gen_i (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.enable       (enable),
		.param_addr   (param_addr),
		.param_count  (param_count),
		.param_maxlen (param_maxlen),
		.aw_cmd       (gen_aw),
		.aw_valid     (gen_aw_valid),
		.aw_ready     (gen_aw_ready),
		.len_cmd      (gen_len),
		.len_valid    (gen_len_valid),
		.len_ready    (gen_len_ready),
		.bvalid       (m_axi_bvalid),
		.bresp        (m_axi_bresp),
		.busy         (gen_busy),
		.resp_error   (resp_error)
	);

	skid_buffer #(.WIDTH($bits(aw_cmd_t))) skid_aw_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (gen_aw),
		.s_valid (gen_aw_valid),
		.s_ready (gen_aw_ready),
		.m_data  (out_aw),
		.m_valid (m_axi_awvalid),
		.m_ready (m_axi_awready)
	);

	// burst lengths queued for the W side
	skid_buffer #(.WIDTH($bits(len_cmd_t))) skid_cmd_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (gen_len),
		.s_valid (gen_len_valid),
		.s_ready (gen_len_ready),
		.m_data  (seq_cmd),
		.m_valid (seq_cmd_valid),
		.m_ready (seq_cmd_ready)
	);

	// --------------------------------------------------
	// data side
	// --------------------------------------------------
	skid_buffer #(.WIDTH(`DMA_DATA_WIDTH)) skid_s_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (s_axis_tdata),
		.s_valid (s_axis_tvalid),
		.s_ready (s_axis_tready),
		.m_data  (seq_s_data),
		.m_valid (seq_s_valid),
		.m_ready (seq_s_ready)
	);

	wdata_sequencer wdata_sequencer_i (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.param_wstrb (param_wstrb),
		.cmd         (seq_cmd),
		.cmd_valid   (seq_cmd_valid),
		.cmd_ready   (seq_cmd_ready),
		.s_data      (seq_s_data),
		.s_valid     (seq_s_valid),
		.s_ready     (seq_s_ready),
		.w_beat      (seq_w),
		.w_valid     (seq_w_valid),
		.w_ready     (seq_w_ready),
		.wstrb       (m_axi_wstrb),
		.wbusy       (wbusy)
	);

	skid_buffer #(.WIDTH($bits(w_beat_t))) skid_w_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (seq_w),
		.s_valid (seq_w_valid),
		.s_ready (seq_w_ready),
		.m_data  (out_w),
		.m_valid (m_axi_wvalid),
		.m_ready (m_axi_wready)
	);

	assign m_axi_awaddr = out_aw.addr;
	assign m_axi_awlen  = out_aw.len;
	assign m_axi_wdata  = out_w.data;
	assign m_axi_wlast  = out_w.last;

	assign busy = gen_busy || wbusy;

endmodule

`default_nettype wire

/* test/axi4_mem_model.sv */
// --------------------------------------------------
// AXI4 write slave model
// word memory, AW burst log, per-beat W log and B
// responses, with SLVERR on one chosen burst address
// --------------------------------------------------

`default_nettype none

`include "dma_defs.svh"

module axi4_mem_model #(
	parameter int DEPTH     = 1024,
	parameter int LOG_DEPTH = 256
) (
	input  wire                         aclk,
	input  wire                         aresetn,

	input  wire  [`DMA_ADDR_WIDTH-1:0]  awaddr,
	input  wire  [`DMA_LEN_WIDTH-1:0]   awlen,
	input  wire                         awvalid,
	output logic                        awready,

	input  wire  [`DMA_DATA_WIDTH-1:0]  wdata,
	input  wire  [`DMA_STRB_WIDTH-1:0]  wstrb,
	input  wire                         wlast,
	input  wire                         wvalid,
	output logic                        wready,

	output logic [1:0]                  bresp,
	output logic                        bvalid,

	// per-cycle accept permission from the testbench
	input  wire                         aw_go,
	input  wire                         w_go,
	input  wire                         b_go,
	input  wire  [`DMA_ADDR_WIDTH-1:0]  err_addr
);

	import dma_pkg::*;

	aw_cmd_t                    aw_log [LOG_DEPTH];
	logic [`DMA_DATA_WIDTH-1:0] mem [DEPTH];
	logic                       beat_last [LOG_DEPTH];
	logic                       beat_exp_last [LOG_DEPTH];
	logic [`DMA_STRB_WIDTH-1:0] beat_strb [LOG_DEPTH];
	logic [`DMA_ADDR_WIDTH-1:0] b_queue [LOG_DEPTH];

	int                         aw_num;
	int                         beat_num;
	int                         w_burst;
	int                         w_beat;
	int                         b_num;
	int                         word_index;
	aw_cmd_t                    w_cmd;

	logic                       awready_r = 1'b0;
	logic                       wready_r = 1'b0;
	logic                       bvalid_r = 1'b0;
	logic [1:0]                 bresp_r = 2'b00;

	assign awready = awready_r;
	assign wready  = wready_r;
	assign bvalid  = bvalid_r;
	assign bresp   = bresp_r;

	// burst that the W beats belong to
	assign w_cmd      = aw_log[w_burst];
	assign word_index = (int'(w_cmd.addr >> `DMA_DATA_SIZE) + w_beat) % DEPTH;

	// fill pattern over the whole word index
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = 32'h6D2B_0000 ^ (32'(i) * 32'h0001_9E37);
		end
	end

	// W waits for its AW, B waits for a finished burst
	always @(negedge aclk) begin
		awready_r <= aw_go;
		wready_r  <= w_go && (w_burst < aw_num);
		bvalid_r  <= b_go && (b_num < w_burst);
		bresp_r   <= (b_queue[b_num] == err_addr) ? 2'b10 : 2'b00;
	end

	// strobes are logged for checking, not applied to memory
	always @(posedge aclk) begin
		if (!aresetn) begin
			aw_num   <= 0;
			beat_num <= 0;
			w_burst  <= 0;
			w_beat   <= 0;
			b_num    <= 0;
		end else begin
			if (awvalid && awready) begin
				aw_log[aw_num] <= {awaddr, awlen};
				aw_num         <= aw_num + 1;
			end
			if (wvalid && wready) begin
				mem[word_index]         <= wdata;
				beat_last[beat_num]     <= wlast;
				beat_exp_last[beat_num] <= (w_beat == int'(w_cmd.len));
				beat_strb[beat_num]     <= wstrb;
				beat_num                <= beat_num + 1;
				if (w_beat == int'(w_cmd.len)) begin
					b_queue[w_burst] <= w_cmd.addr;
					w_burst          <= w_burst + 1;
					w_beat           <= 0;
				end else begin
					w_beat <= w_beat + 1;
				end
			end
			// bready is always high
			if (bvalid) begin
				b_num <= b_num + 1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_dma_writer.sv */
// --------------------------------------------------
// DMA writer testbench
// runs a table of transfers into a stalling AXI4 slave
// model, checks bursts, data, strobes, wlast, busy
// and the response error flag
// --------------------------------------------------

`default_nettype none

`include "dma_defs.svh"

module tb_dma_writer;

	import dma_pkg::*;

	localparam int          NUM_TESTS   = 7;
	localparam int          MEM_DEPTH   = 1024;
	localparam logic [31:0] SEED        = 32'd92817;
	localparam logic [31:0] NO_ERR_ADDR = 32'hFFFF_FFFC;

	// ---------------- transfer table ----------------
	int   test_addr   [NUM_TESTS] = '{'h000, 'h040, 'h100, 'h200, 'h300, 'h400, 'h500};
	int   test_count  [NUM_TESTS] = '{3, 8, 32, 21, 40, 17, 1};
	int   test_maxlen [NUM_TESTS] = '{7, 7, 7, 3, 15, 15, 0};
	int   test_strb   [NUM_TESTS] = '{'hF, 'hF, 'hF, 'h3, 'hF, 'hC, 'hF};
	// burst index that gets SLVERR, -1 for none
	int   test_err    [NUM_TESTS] = '{-1, -1, -1, -1, 1, -1, -1};
	logic test_stall  [NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

	logic                         aclk = 1'b0;
	logic                         aresetn = 1'b0;
	logic                         enable = 1'b0;
	logic                         busy;
	logic                         resp_error;
	logic [`DMA_ADDR_WIDTH-1:0]   param_addr = '0;
	logic [`DMA_COUNT_WIDTH-1:0]  param_count = '0;
	logic [`DMA_LEN_WIDTH-1:0]    param_maxlen = '0;
	logic [`DMA_STRB_WIDTH-1:0]   param_wstrb = '0;
	logic [`DMA_DATA_WIDTH-1:0]   s_axis_tdata = '0;
	logic                         s_axis_tvalid = 1'b0;
	logic                         s_axis_tready;
	logic [`DMA_ADDR_WIDTH-1:0]   m_axi_awaddr;
	logic [`DMA_LEN_WIDTH-1:0]    m_axi_awlen;
	logic                         m_axi_awvalid;
	logic                         m_axi_awready;
	logic [`DMA_DATA_WIDTH-1:0]   m_axi_wdata;
	logic [`DMA_STRB_WIDTH-1:0]   m_axi_wstrb;
	logic                         m_axi_wlast;
	logic                         m_axi_wvalid;
	logic                         m_axi_wready;
	logic [1:0]                   m_axi_bresp;
	logic                         m_axi_bvalid;

	logic                         aw_go = 1'b0;
	logic                         w_go = 1'b0;
	logic                         b_go = 1'b0;
	logic [`DMA_ADDR_WIDTH-1:0]   err_addr = NO_ERR_ADDR;
	logic                         stall_on = 1'b0;

	// stream source state
	int                           words_sent = 0;
	logic                         word_taken = 1'b0;
	int                           stream_first = 0;
	int                           stream_end = 0;
	logic [`DMA_DATA_WIDTH-1:0]   stream_base = '0;

	// transfer under test, for the AW compare
	logic [`DMA_ADDR_WIDTH-1:0]   cur_addr = '0;
	int                           cur_count = 0;
	int                           cur_maxlen = 0;
	int                           aw_first = 0;
	int                           aw_checked = 0;

	logic [31:0]                  lfsr_state = SEED;
	int                           cycles = 0;
	int                           cycle_limit = 0;
	int                           aw_errs = 0;
	int                           word_errs = 0;
	int                           strb_errs = 0;
	int                           flag_errs = 0;

	always #20 aclk = ~aclk;

	axi4_dma_writer dut_i (.*);

	axi4_mem_model #(.DEPTH(MEM_DEPTH)) mem_i (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.awaddr   (m_axi_awaddr),
		.awlen    (m_axi_awlen),
		.awvalid  (m_axi_awvalid),
		.awready  (m_axi_awready),
		.wdata    (m_axi_wdata),
		.wstrb    (m_axi_wstrb),
		.wlast    (m_axi_wlast),
		.wvalid   (m_axi_wvalid),
		.wready   (m_axi_wready),
		.bresp    (m_axi_bresp),
		.bvalid   (m_axi_bvalid),
		.aw_go    (aw_go),
		.w_go     (w_go),
		.b_go     (b_go),
		.err_addr (err_addr)
	);

	// ---------------- helpers ----------------
	// galois form, taps 32 22 2 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_bit(output logic b);
		lfsr_state = next_lfsr(lfsr_state);
		b = lfsr_state[0];
	endtask

	function automatic int burst_total(input int count, input int maxlen);
		return (count + maxlen) / (maxlen + 1);
	endfunction

	// i-th burst: maxlen+1 beats, the last one shorter
	function automatic aw_cmd_t expected_burst(input logic [31:0] addr, input int count,
		input int maxlen, input int idx);
		aw_cmd_t cmd;
		int      beats;
		int      left;
		beats    = maxlen + 1;
		left     = count - idx * beats;
		cmd.addr = addr + 32'(idx * beats * (1 << `DMA_DATA_SIZE));
		cmd.len  = 8'(((left < beats) ? left : beats) - 1);
		return cmd;
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		return 32'h6D2B_0000 ^ (32'(idx) * 32'h0001_9E37);
	endfunction

	task automatic check_aw(input aw_cmd_t got, input aw_cmd_t exp);
		if (got !== exp) begin
			aw_errs++;
			$display("Error: m_axi_awaddr/m_axi_awlen got 0x%h/0x%h expected 0x%h/0x%h",
				got.addr, got.len, exp.addr, exp.len);
		end
	endtask

	task automatic check_word(input string name, input logic [`DMA_DATA_WIDTH-1:0] got,
		input logic [`DMA_DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			word_errs++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_strb(input logic [`DMA_STRB_WIDTH-1:0] got,
		input logic [`DMA_STRB_WIDTH-1:0] exp);
		if (got !== exp) begin
			strb_errs++;
			$display("Error: m_axi_wstrb got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// ---------------- stimulus ----------------
	always @(posedge aclk) begin
		word_taken <= s_axis_tvalid && s_axis_tready;
		if (s_axis_tvalid && s_axis_tready) begin
			words_sent <= words_sent + 1;
		end
	end

	// all random bits are taken here, in one fixed order
	always @(negedge aclk) begin
		logic bit_v;
		random_bit(bit_v);
		aw_go <= !stall_on || bit_v;
		random_bit(bit_v);
		w_go <= !stall_on || bit_v;
		random_bit(bit_v);
		b_go <= !stall_on || bit_v;
		// tvalid holds until its word is taken
		if (!s_axis_tvalid || word_taken) begin
			random_bit(bit_v);
			s_axis_tvalid = (words_sent < stream_end) && (!stall_on || bit_v);
			s_axis_tdata  = stream_base + 32'(words_sent - stream_first);
		end
	end

	// AW compare against the reference bursts
	always @(negedge aclk) begin
		while (aw_checked < mem_i.aw_num) begin
			check_aw(mem_i.aw_log[aw_checked],
				expected_burst(cur_addr, cur_count, cur_maxlen, aw_checked - aw_first));
			aw_checked++;
		end
	end

	always @(posedge aclk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	// ---------------- test sequence ----------------
	initial begin
		int          total;
		int          nb;
		int          word0;
		int          beat_first;
		int          b_first;
		int          aw_start;
		logic        exp_err;
		logic [31:0] base;
		aw_cmd_t     err_cmd;

		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += test_count[t];
		end
		cycle_limit = 20 * total + 2000;

		repeat (10) @(negedge aclk);
		check_flag("busy", busy, 1'b0);
		check_flag("m_axi_awvalid", m_axi_awvalid, 1'b0);
		check_flag("m_axi_wvalid", m_axi_wvalid, 1'b0);
		check_flag("s_axis_tready", s_axis_tready, 1'b0);
		check_flag("resp_error", resp_error, 1'b0);
		aresetn = 1'b1;
		repeat (3) @(negedge aclk);

		for (int t = 0; t < NUM_TESTS; t++) begin
			base       = 32'(t + 1) << 24;
			nb         = burst_total(test_count[t], test_maxlen[t]);
			exp_err    = (test_err[t] >= 0);
			beat_first = mem_i.beat_num;
			b_first    = mem_i.b_num;
			aw_start   = mem_i.aw_num;

			param_addr   = test_addr[t];
			param_count  = test_count[t];
			param_maxlen = test_maxlen[t];
			param_wstrb  = test_strb[t];

			cur_addr     <= test_addr[t];
			cur_count    <= test_count[t];
			cur_maxlen   <= test_maxlen[t];
			aw_first     <= mem_i.aw_num;
			stream_first <= words_sent;
			stream_end   <= words_sent + test_count[t];
			stream_base  <= base;
			stall_on     <= test_stall[t];
			if (exp_err) begin
				err_cmd = expected_burst(test_addr[t], test_count[t], test_maxlen[t],
					test_err[t]);
				err_addr <= err_cmd.addr;
			end else begin
				err_addr <= NO_ERR_ADDR;
			end

			enable = 1'b1;
			@(negedge aclk);
			enable = 1'b0;
			check_flag("busy", busy, 1'b1);
			while (busy) begin
				@(negedge aclk);
			end

			// busy low only once every B is back
			check_flag("all bursts issued", (mem_i.aw_num - aw_start) == nb, 1'b1);
			check_flag("all B responses back", (mem_i.b_num - b_first) == nb, 1'b1);
			check_flag("all beats written", (mem_i.beat_num - beat_first) == test_count[t],
				1'b1);
			check_flag("resp_error", resp_error, exp_err);

			for (int k = beat_first; k < mem_i.beat_num; k++) begin
				check_flag("m_axi_wlast", mem_i.beat_last[k], mem_i.beat_exp_last[k]);
				check_strb(mem_i.beat_strb[k], test_strb[t]);
			end

			word0 = test_addr[t] >> `DMA_DATA_SIZE;
			for (int k = 0; k < test_count[t]; k++) begin
				check_word("m_axi_wdata in memory", mem_i.mem[word0 + k], base + 32'(k));
			end
			check_word("memory past transfer", mem_i.mem[word0 + test_count[t]],
				fill_word(word0 + test_count[t]));

			repeat (4) @(negedge aclk);
		end

		$display("errors: aw %0d, word %0d, strb %0d, flag %0d",
			aw_errs, word_errs, strb_errs, flag_errs);
		if (aw_errs + word_errs + strb_errs + flag_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/dma_pkg.sv
rtl/skid_buffer.sv
rtl/burst_addr_gen.sv
rtl/wdata_sequencer.sv
rtl/axi4_dma_writer.sv
test/axi4_mem_model.sv
test/tb_dma_writer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DMA writer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f sources.f \
	--top-module tb_dma_writer \
	-o tb_dma_writer_sim

./obj_dir/tb_dma_writer_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
